/* include/dbg_defines.svh */
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// byte and data widths
`define DBG_BYTE        8
`define DBG_WORD        32

// instruction memory byte address, 256 bytes or 64 words
`define DBG_IM_ADDR     8

// register file address, eight registers
`define DBG_RB_ADDR     3

// data memory word address, 32 words
`define DBG_DM_ADDR     5

// data memory words sent in a dump
`define DBG_DUMP_WORDS  8

// width of the status output
`define DBG_NB_STATE    8

`endif

/* source/dbg_pkg.sv */
package dbg_pkg;

    // instruction opcodes, bits 31 to 28 of an instruction
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_ADDI = 4'd3,
        OP_LW   = 4'd4,
        OP_SW   = 4'd5,
        OP_BEQ  = 4'd6,
        OP_HALT = 4'd7
    } opcode_e;

    // debug front end states
    typedef enum logic [2:0] {
        DU_IDLE       = 3'd0,
        DU_LOAD_COUNT = 3'd1,
        DU_LOAD_BYTES = 3'd2,
        DU_RUN        = 3'd3,
        DU_STEP       = 3'd4,
        DU_DUMP       = 3'd5
    } du_state_e;

    // host command bytes, ascii
    localparam logic [7:0] CMD_LOAD = 8'h4C;
    localparam logic [7:0] CMD_RUN  = 8'h52;
    localparam logic [7:0] CMD_STEP = 8'h53;
    localparam logic [7:0] CMD_DUMP = 8'h44;

endpackage

/* source/debug_command.sv */
`include "dbg_defines.svh"

module debug_command (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_rx_done,
    input  logic [`DBG_BYTE-1:0]    i_rx_data,
    input  logic                    i_halt,
    input  logic                    i_dump_busy,
    output logic                    o_im_we,
    output logic [`DBG_IM_ADDR-1:0] o_im_addr,
    output logic [`DBG_BYTE-1:0]    o_im_data,
    output logic                    o_pc_clear,
    output logic                    o_exec_en,
    output logic                    o_dump_start,
    output dbg_pkg::du_state_e      o_du_state
);

    dbg_pkg::du_state_e      state;
    logic [`DBG_IM_ADDR-1:0] load_addr;
    logic [`DBG_IM_ADDR-1:0] last_addr;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state        <= dbg_pkg::DU_IDLE;
            load_addr    <= '0;
            last_addr    <= '0;
            o_im_we      <= 1'b0;
            o_dump_start <= 1'b0;
        end else begin
            o_im_we      <= 1'b0;
            o_dump_start <= 1'b0;
            case (state)
                dbg_pkg::DU_IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            dbg_pkg::CMD_LOAD: state <= dbg_pkg::DU_LOAD_COUNT;
                            dbg_pkg::CMD_RUN:  state <= dbg_pkg::DU_RUN;
                            dbg_pkg::CMD_STEP: begin
                                // a halted core takes no step
                                if (!i_halt) begin
                                    state <= dbg_pkg::DU_STEP;
                                end
                            end
                            dbg_pkg::CMD_DUMP: begin
                                state        <= dbg_pkg::DU_DUMP;
                                o_dump_start <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                dbg_pkg::DU_LOAD_COUNT: begin
                    if (i_rx_done) begin
                        // count of 0 wraps to 64 words
                        last_addr <= {i_rx_data[`DBG_IM_ADDR-3:0] - 1'b1, 2'b11};
                        load_addr <= '0;
                        state     <= dbg_pkg::DU_LOAD_BYTES;
                    end
                end
                dbg_pkg::DU_LOAD_BYTES: begin
                    if (i_rx_done) begin
                        o_im_we   <= 1'b1;
                        load_addr <= load_addr + 1'b1;
                        if (load_addr == last_addr) begin
                            state <= dbg_pkg::DU_IDLE;
                        end
                    end
                end
                dbg_pkg::DU_RUN: begin
                    if (i_halt) begin
                        state <= dbg_pkg::DU_IDLE;
                    end
                end
                dbg_pkg::DU_STEP: state <= dbg_pkg::DU_IDLE;
                dbg_pkg::DU_DUMP: begin
                    // busy rises one cycle after the start pulse
                    if (!o_dump_start && !i_dump_busy) begin
                        state <= dbg_pkg::DU_IDLE;
                    end
                end
                default: state <= dbg_pkg::DU_IDLE;
            endcase
        end
    end

    // write address and byte for the im_we pulse
    always_ff @(posedge i_clock) begin
        if (i_rx_done) begin
            o_im_addr <= load_addr;
            o_im_data <= i_rx_data;
        end
    end

    assign o_pc_clear = (state == dbg_pkg::DU_LOAD_COUNT) && i_rx_done;

    assign o_exec_en = ((state == dbg_pkg::DU_RUN) && !i_halt) ||
                       (state == dbg_pkg::DU_STEP);

    assign o_du_state = state;

endmodule

/* source/cpu_core.sv */
`include "dbg_defines.svh"

module cpu_core (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_exec_en,
    input  logic                    i_pc_clear,
    input  logic                    i_im_we,
    input  logic [`DBG_IM_ADDR-1:0] i_im_addr,
    input  logic [`DBG_BYTE-1:0]    i_im_data,
    input  logic [`DBG_RB_ADDR-1:0] i_rb_addr,
    input  logic [`DBG_DM_ADDR-1:0] i_dm_addr,
    output logic [`DBG_WORD-1:0]    o_pc,
    output logic                    o_halt,
    output logic [`DBG_WORD-1:0]    o_rb_data,
    output logic [`DBG_WORD-1:0]    o_dm_data
);

    localparam int NB_IM_WORD = `DBG_IM_ADDR - 2;
    localparam int N_IM_WORDS = 2 ** NB_IM_WORD;
    localparam int N_REGS     = 2 ** `DBG_RB_ADDR;
    localparam int N_DM_WORDS = 2 ** `DBG_DM_ADDR;

    logic [`DBG_WORD-1:0]    imem [N_IM_WORDS];
    logic [`DBG_WORD-1:0]    regs [N_REGS];
    logic [`DBG_WORD-1:0]    dmem [N_DM_WORDS];

    logic [`DBG_WORD-1:0]    pc;
    logic                    halted;
    logic [`DBG_WORD-1:0]    instr;
    dbg_pkg::opcode_e        opcode;
    logic [`DBG_RB_ADDR-1:0] rd;
    logic [`DBG_RB_ADDR-1:0] rs;
    logic [`DBG_RB_ADDR-1:0] rt;
    logic [`DBG_WORD-1:0]    imm;
    logic [`DBG_WORD-1:0]    rs_val;
    logic [`DBG_WORD-1:0]    rt_val;
    logic [`DBG_WORD-1:0]    addr_sum;
    logic [`DBG_DM_ADDR-1:0] mem_addr;
    logic [`DBG_WORD-1:0]    pc_next;
    logic                    wb_en;
    logic [`DBG_WORD-1:0]    wb_data;
    logic                    dm_we;
    logic                    set_halt;

    // fetch and field decode
    assign instr  = imem[pc[NB_IM_WORD-1:0]];
    assign opcode = dbg_pkg::opcode_e'(instr[31:28]);
    assign rd     = instr[24 +: `DBG_RB_ADDR];
    assign rs     = instr[20 +: `DBG_RB_ADDR];
    assign rt     = instr[16 +: `DBG_RB_ADDR];
    assign imm    = {{(`DBG_WORD-16){instr[15]}}, instr[15:0]};

    assign rs_val   = regs[rs];
    assign rt_val   = regs[rt];
    assign addr_sum = rs_val + imm;
    // data address wraps modulo memory size
    assign mem_addr = addr_sum[`DBG_DM_ADDR-1:0];

    always_comb begin
        pc_next  = pc + 1'b1;
        wb_en    = 1'b0;
        wb_data  = '0;
        dm_we    = 1'b0;
        set_halt = 1'b0;
        case (opcode)
            dbg_pkg::OP_ADD: begin
                wb_en   = 1'b1;
                wb_data = rs_val + rt_val;
            end
            dbg_pkg::OP_SUB: begin
                wb_en   = 1'b1;
                wb_data = rs_val - rt_val;
            end
            dbg_pkg::OP_ADDI: begin
                wb_en   = 1'b1;
                wb_data = addr_sum;
            end
            dbg_pkg::OP_LW: begin
                wb_en   = 1'b1;
                wb_data = dmem[mem_addr];
            end
            dbg_pkg::OP_SW: dm_we = 1'b1;
            dbg_pkg::OP_BEQ: begin
                if (rs_val == rt_val) begin
                    pc_next = pc + 1'b1 + imm;
                end
            end
            dbg_pkg::OP_HALT: begin
                // pc stays on the halt
                pc_next  = pc;
                set_halt = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (i_pc_clear) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (i_exec_en) begin
            pc <= pc_next;
            if (set_halt) begin
                halted <= 1'b1;
            end
        end
    end

    // r0 is never written
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_exec_en && wb_en && (rd != '0)) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_exec_en && dm_we) begin
            dmem[mem_addr] <= rt_val;
        end
    end

    // program bytes land in their lane of the word
    always_ff @(posedge i_clock) begin
        if (i_im_we) begin
            imem[i_im_addr[`DBG_IM_ADDR-1:2]][8*i_im_addr[1:0] +: `DBG_BYTE] <= i_im_data;
        end
    end

    assign o_pc      = pc;
    assign o_halt    = halted;
    assign o_rb_data = regs[i_rb_addr];
    assign o_dm_data = dmem[i_dm_addr];

endmodule

/* source/debug_dump.sv */
`include "dbg_defines.svh"

module debug_dump (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_dump_start,
    input  logic                    i_tx_done,
    input  logic [`DBG_WORD-1:0]    i_pc,
    input  logic [`DBG_WORD-1:0]    i_rb_data,
    input  logic [`DBG_WORD-1:0]    i_dm_data,
    output logic [`DBG_RB_ADDR-1:0] o_rb_addr,
    output logic [`DBG_DM_ADDR-1:0] o_dm_addr,
    output logic [`DBG_BYTE-1:0]    o_tx_data,
    output logic                    o_tx_start,
    output logic                    o_dump_busy
);

    localparam int NB_LANES = `DBG_WORD / `DBG_BYTE;
    localparam int NB_DUMP  = NB_LANES * (1 + 2 ** `DBG_RB_ADDR + `DBG_DUMP_WORDS);
    localparam int NB_CNT   = $clog2(NB_DUMP);
    localparam int NB_LANE  = $clog2(NB_LANES);
    localparam int NB_WSEL  = NB_CNT - NB_LANE;
    localparam int RB_FIRST = 1;
    localparam int DM_FIRST = 1 + 2 ** `DBG_RB_ADDR;

    logic [NB_CNT-1:0]    cnt;
    logic [NB_WSEL-1:0]   word_sel;
    logic [NB_LANE-1:0]   lane;
    logic [NB_WSEL-1:0]   rb_index;
    logic [NB_WSEL-1:0]   dm_index;
    logic [`DBG_WORD-1:0] word;

    // upper counter bits pick the word, lower bits the byte
    assign word_sel = cnt[NB_CNT-1:NB_LANE];
    assign lane     = cnt[NB_LANE-1:0];

    assign rb_index  = word_sel - NB_WSEL'(RB_FIRST);
    assign dm_index  = word_sel - NB_WSEL'(DM_FIRST);
    assign o_rb_addr = rb_index[`DBG_RB_ADDR-1:0];
    assign o_dm_addr = `DBG_DM_ADDR'(dm_index);

    // pc, then r0..r7, then data words
    always_comb begin
        if (word_sel == '0) begin
            word = i_pc;
        end else if (word_sel < NB_WSEL'(DM_FIRST)) begin
            word = i_rb_data;
        end else begin
            word = i_dm_data;
        end
    end

    assign o_tx_data = word[lane*`DBG_BYTE +: `DBG_BYTE];

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            cnt         <= '0;
            o_dump_busy <= 1'b0;
            o_tx_start  <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            if (!o_dump_busy) begin
                if (i_dump_start) begin
                    cnt         <= '0;
                    o_dump_busy <= 1'b1;
                    o_tx_start  <= 1'b1;
                end
            end else if (i_tx_done) begin
                if (cnt == NB_CNT'(NB_DUMP - 1)) begin
                    o_dump_busy <= 1'b0;
                end else begin
                    cnt        <= cnt + 1'b1;
                    o_tx_start <= 1'b1;
                end
            end
        end
    end

endmodule

/* source/debug_soc_top.sv */
`include "dbg_defines.svh"

module debug_soc_top (
    input  logic                     i_clock,
    input  logic                     i_rst_n,
    input  logic                     i_rx_done,
    input  logic [`DBG_BYTE-1:0]     i_rx_data,
    input  logic                     i_tx_done,
    output logic [`DBG_BYTE-1:0]     o_tx_data,
    output logic                     o_tx_start,
    output logic [`DBG_NB_STATE-1:0] o_state
);

    localparam int NB_PAD = `DBG_NB_STATE - 1 - $bits(dbg_pkg::du_state_e);

    logic                    im_we;
    logic [`DBG_IM_ADDR-1:0] im_addr;
    logic [`DBG_BYTE-1:0]    im_data;
    logic                    pc_clear;
    logic                    exec_en;
    logic                    dump_start;
    logic                    dump_busy;
    logic                    halt;
    dbg_pkg::du_state_e      du_state;
    logic [`DBG_WORD-1:0]    pc;
    logic [`DBG_RB_ADDR-1:0] rb_addr;
    logic [`DBG_WORD-1:0]    rb_data;
    logic [`DBG_DM_ADDR-1:0] dm_addr;
    logic [`DBG_WORD-1:0]    dm_data;

    debug_command u_debug_command (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .i_halt       (halt),
        .i_dump_busy  (dump_busy),
        .o_im_we      (im_we),
        .o_im_addr    (im_addr),
        .o_im_data    (im_data),
        .o_pc_clear   (pc_clear),
        .o_exec_en    (exec_en),
        .o_dump_start (dump_start),
        .o_du_state   (du_state)
    );

    cpu_core u_cpu_core (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_exec_en  (exec_en),
        .i_pc_clear (pc_clear),
        .i_im_we    (im_we),
        .i_im_addr  (im_addr),
        .i_im_data  (im_data),
        .i_rb_addr  (rb_addr),
        .i_dm_addr  (dm_addr),
        .o_pc       (pc),
        .o_halt     (halt),
        .o_rb_data  (rb_data),
        .o_dm_data  (dm_data)
    );

    debug_dump u_debug_dump (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_dump_start (dump_start),
        .i_tx_done    (i_tx_done),
        .i_pc         (pc),
        .i_rb_data    (rb_data),
        .i_dm_data    (dm_data),
        .o_rb_addr    (rb_addr),
        .o_dm_addr    (dm_addr),
        .o_tx_data    (o_tx_data),
        .o_tx_start   (o_tx_start),
        .o_dump_busy  (dump_busy)
    );

    // halted flag on top, debug state in the low bits
    assign o_state = {halt, {NB_PAD{1'b0}}, du_state};

endmodule

/* sim/tb_clock.sv */
module tb_clock (
    output logic o_clock
);

    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        o_clock = 1'b0;
        forever #50 o_clock = ~o_clock;
    end

endmodule

/* sim/debug_soc_checker.sv */
module debug_soc_checker (
    input logic i_clock,
    input logic i_rst_n,
    input logic i_tx_start,
    input logic i_tx_done,
    input logic i_dump_start
);

    timeunit 1ns;
    timeprecision 100ps;

    logic waiting;
    logic dump_seen;
    int   n_fail = 0;

    // a start is outstanding until its done pulse
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            waiting   <= 1'b0;
            dump_seen <= 1'b0;
        end else begin
            if (i_tx_start) begin
                waiting <= 1'b1;
            end else if (i_tx_done) begin
                waiting <= 1'b0;
            end
            if (i_dump_start) begin
                dump_seen <= 1'b1;
            end
        end
    end

    a_start_single: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_tx_start |=> !i_tx_start)
    else begin
        n_fail++;
        $error("tx start high in two consecutive cycles");
    end

    a_start_waits: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        waiting |-> !i_tx_start)
    else begin
        n_fail++;
        $error("tx start issued before tx done of the previous byte");
    end

    a_no_early_start: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !dump_seen |-> !i_tx_start)
    else begin
        n_fail++;
        $error("tx start issued before any dump request");
    end

endmodule

bind debug_soc_top debug_soc_checker u_checker (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_tx_start   (o_tx_start),
    .i_tx_done    (i_tx_done),
    .i_dump_start (dump_start)
);

/* sim/tb_debug_soc.sv */
`include "dbg_defines.svh"

module tb_debug_soc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_STEPS  = 6;
    localparam int N_TESTS  = 3 + N_STEPS;
    localparam int N_DUMP   = 4 * (1 + 8 + `DBG_DUMP_WORDS);
    localparam int HALT_IDX = 12;
    localparam int DRIVE_NS = 10;

    logic        clock;
    logic        rst_n;
    logic        rx_done;
    logic [7:0]  rx_data;
    logic        tx_done;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic [7:0]  state;

    int          seed = 32;
    logic [7:0]  tx_bytes [$];
    logic [7:0]  prev_bytes [$];
    logic [31:0] prog [$];

    // reference model
    logic [31:0] m_imem [64];
    logic [31:0] m_regs [8];
    logic [31:0] m_dmem [32];
    logic [31:0] m_pc;
    logic        m_halted;

    tb_clock u_clock (
        .o_clock (clock)
    );

    debug_soc_top dut (
        .i_clock    (clock),
        .i_rst_n    (rst_n),
        .i_rx_done  (rx_done),
        .i_rx_data  (rx_data),
        .i_tx_done  (tx_done),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start),
        .o_state    (state)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] encode_instr(dbg_pkg::opcode_e op, int rd, int rs,
                                                 int rt, int imm);
        return {op, 1'b0, rd[2:0], 1'b0, rs[2:0], 1'b0, rt[2:0], imm[15:0]};
    endfunction

    // one instruction by the ISA rules
    task automatic model_exec;
        logic [31:0] instr;
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic [31:0] wb;
        logic        wb_en;
        logic [2:0]  rd;
        instr   = m_imem[m_pc[5:0]];
        rd      = instr[26:24];
        rs_v    = m_regs[instr[22:20]];
        rt_v    = m_regs[instr[18:16]];
        imm     = {{16{instr[15]}}, instr[15:0]};
        addr    = rs_v + imm;
        next_pc = m_pc + 32'd1;
        wb      = '0;
        wb_en   = 1'b0;
        case (dbg_pkg::opcode_e'(instr[31:28]))
            dbg_pkg::OP_ADD: begin
                wb_en = 1'b1;
                wb    = rs_v + rt_v;
            end
            dbg_pkg::OP_SUB: begin
                wb_en = 1'b1;
                wb    = rs_v - rt_v;
            end
            dbg_pkg::OP_ADDI: begin
                wb_en = 1'b1;
                wb    = addr;
            end
            dbg_pkg::OP_LW: begin
                wb_en = 1'b1;
                wb    = m_dmem[addr[4:0]];
            end
            dbg_pkg::OP_SW: m_dmem[addr[4:0]] = rt_v;
            dbg_pkg::OP_BEQ: begin
                if (rs_v == rt_v) begin
                    next_pc = m_pc + 32'd1 + imm;
                end
            end
            dbg_pkg::OP_HALT: begin
                next_pc  = m_pc;
                m_halted = 1'b1;
            end
            default: ;
        endcase
        if (wb_en && rd != 3'd0) begin
            m_regs[rd] = wb;
        end
        m_pc = next_pc;
    endtask

    // pc, r0..r7, data words, each lsb first
    function automatic logic [7:0] expected_byte(int idx);
        int          w;
        int          lane;
        logic [31:0] word;
        w    = idx / 4;
        lane = idx % 4;
        if (w == 0) begin
            word = m_pc;
        end else if (w <= 8) begin
            word = m_regs[3'(w - 1)];
        end else begin
            word = m_dmem[5'(w - 9)];
        end
        return word[8*lane +: 8];
    endfunction

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = 1 + int'($unsigned($random(seed)) % 8);
        repeat (gap) @(posedge clock);
        #DRIVE_NS;
        rx_done = 1'b1;
        rx_data = b;
        @(posedge clock);
        #DRIVE_NS;
        rx_done = 1'b0;
    endtask

    task automatic wait_idle;
        while (state[2:0] != dbg_pkg::DU_IDLE) begin
            @(posedge clock);
            #DRIVE_NS;
        end
    endtask

    task automatic load_program;
        send_byte(dbg_pkg::CMD_LOAD);
        send_byte(8'(prog.size()));
        foreach (prog[i]) begin
            for (int b = 0; b < 4; b++) begin
                send_byte(prog[i][8*b +: 8]);
            end
            m_imem[6'(i)] = prog[i];
        end
        m_pc     = '0;
        m_halted = 1'b0;
    endtask

    task automatic dump_and_check(input string name);
        tx_bytes.delete();
        send_byte(dbg_pkg::CMD_DUMP);
        wait_idle();
        assert (tx_bytes.size() == N_DUMP)
        else abort_run($sformatf("error %s: expected %0d bytes, actual %0d",
                                 name, N_DUMP, tx_bytes.size()));
        for (int i = 0; i < N_DUMP; i++) begin
            assert (tx_bytes[i] === expected_byte(i))
            else abort_run($sformatf("error %s byte %0d: expected %h, actual %h",
                                     name, i, expected_byte(i), tx_bytes[i]));
        end
    endtask

    // host side of the uart, answers every start
    initial begin
        int tx_wait;
        tx_done = 1'b0;
        tx_wait = 0;
        forever begin
            @(posedge clock);
            #DRIVE_NS;
            tx_done = 1'b0;
            if (tx_wait > 0) begin
                tx_wait = tx_wait - 1;
                if (tx_wait == 0) begin
                    tx_done = 1'b1;
                end
            end else if (tx_start === 1'b1) begin
                tx_bytes.push_back(tx_data);
                tx_wait = 1 + int'($unsigned($random(seed)) % 20);
            end
        end
    end

    always @(posedge clock) begin
        #DRIVE_NS;
        if (dut.u_checker.n_fail != 0) begin
            abort_run("a bound assertion on the transmit strobes failed");
        end
    end

    initial begin
        repeat (N_TESTS * 4000 + 1000) @(posedge clock);
        abort_run("timeout: the tests did not finish in time");
    end

    initial begin
        logic [31:0] dumped_pc;
        rst_n   = 1'b0;
        rx_done = 1'b0;
        rx_data = 8'h00;

        // fill dmem 0..7 with their index in a loop, then alu, memory and branch checks
        prog.push_back(encode_instr(dbg_pkg::OP_ADDI, 1, 0, 0, 8));
        prog.push_back(encode_instr(dbg_pkg::OP_ADDI, 1, 1, 0, -1));
        prog.push_back(encode_instr(dbg_pkg::OP_SW,   0, 1, 1, 0));
        prog.push_back(encode_instr(dbg_pkg::OP_BEQ,  0, 1, 0, 1));
        prog.push_back(encode_instr(dbg_pkg::OP_BEQ,  0, 0, 0, -4));
        prog.push_back(encode_instr(dbg_pkg::OP_ADDI, 3, 0, 0, 100));
        prog.push_back(encode_instr(dbg_pkg::OP_LW,   4, 0, 0, 5));
        prog.push_back(encode_instr(dbg_pkg::OP_ADD,  5, 3, 4, 0));
        prog.push_back(encode_instr(dbg_pkg::OP_SUB,  6, 4, 3, 0));
        prog.push_back(encode_instr(dbg_pkg::OP_SW,   0, 4, 5, -2));
        // address 35 wraps to word 3
        prog.push_back(encode_instr(dbg_pkg::OP_LW,   7, 0, 0, 35));
        prog.push_back(encode_instr(dbg_pkg::OP_NOP,  0, 0, 0, 0));
        prog.push_back(encode_instr(dbg_pkg::OP_HALT, 0, 0, 0, 0));

        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_dmem[i]) m_dmem[i] = '0;
        foreach (m_imem[i]) m_imem[i] = '0;
        m_pc     = '0;
        m_halted = 1'b0;

        repeat (10) @(posedge clock);
        #DRIVE_NS;
        rst_n = 1'b1;

        assert (state === 8'h00 && tx_start === 1'b0)
        else abort_run($sformatf("error reset: expected state 00 start 0, actual state %h start %b",
                                 state, tx_start));

        load_program();
        send_byte(dbg_pkg::CMD_RUN);
        while (!(state[7] === 1'b1 && state[2:0] == dbg_pkg::DU_IDLE)) begin
            @(posedge clock);
            #DRIVE_NS;
        end
        while (!m_halted) model_exec();
        dump_and_check("load_run");
        dumped_pc = {tx_bytes[3], tx_bytes[2], tx_bytes[1], tx_bytes[0]};
        assert (dumped_pc == 32'(HALT_IDX) && state[7] === 1'b1)
        else abort_run($sformatf("error load_run pc: expected %0d halted, actual %0d state %h",
                                 HALT_IDX, dumped_pc, state));

        // a step on a halted core changes nothing
        prev_bytes = tx_bytes;
        send_byte(dbg_pkg::CMD_STEP);
        dump_and_check("halt_step");
        foreach (prev_bytes[i]) begin
            assert (tx_bytes[i] === prev_bytes[i])
            else abort_run($sformatf("error halt_step byte %0d: expected %h, actual %h",
                                     i, prev_bytes[i], tx_bytes[i]));
        end

        load_program();
        for (int k = 1; k <= N_STEPS; k++) begin
            send_byte(dbg_pkg::CMD_STEP);
            if (!m_halted) model_exec();
            dump_and_check($sformatf("step_%0d", k));
        end

        if (dut.u_checker.n_fail == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

/* all.f */
+incdir+include
source/dbg_pkg.sv
source/debug_command.sv
source/cpu_core.sv
source/debug_dump.sv
source/debug_soc_top.sv
sim/tb_clock.sv
sim/debug_soc_checker.sv
sim/tb_debug_soc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_debug_soc
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
